/* Bender.yml */
package:
  name: periph_soc

sources:
  - hdl/periph_pkg.sv
  - hdl/periph_slot_if.sv
  - hdl/sync_fifo.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_slot.sv
  - hdl/periph_soc.sv
  - target: test
    files:
      - tb/tb_periph_soc.sv

/* all.f */
hdl/periph_pkg.sv
hdl/periph_slot_if.sv
hdl/sync_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_slot.sv
hdl/periph_soc.sv
tb/tb_periph_soc.sv

/* hdl/periph_pkg.sv */
//********************
// peripheral package
// bus widths, slot map, UART register
// codes and shared types
//********************

package periph_pkg;

   // host bus
   typedef logic [17:0] addr_t;          // word address
   typedef logic [63:0] data_t;
   typedef logic [7:0]  be_t;            // byte write enables
   typedef logic [2:0]  slot_t;          // addr bits 17..15

   // uart payload and counters
   typedef logic [7:0]  uart_byte_t;
   typedef logic [8:0]  rx_entry_t;      // framing error above byte
   typedef logic [15:0] baud_t;          // clocks per serial bit
   typedef logic [11:0] fifo_cnt_t;      // wrapping push/pop count

   typedef enum logic [2:0]
   {
      UTX_IDLE,
      UTX_EMPTY,
      UTX_POP,
      UTX_START,
      UTX_INUSE
   } utx_state_t;

   // slot numbers
   localparam int SLOT_CTRL = 2;         // led and dip switches
   localparam int SLOT_UART = 6;

   // control slot word offsets, addr bits 7..3
   localparam int OFS_LED = 15;
   localparam int OFS_DIP = 31;

   // uart slot decode
   localparam int UART_SEL_BIT = 14;     // low selects the old keyboard space
   localparam int UART_OP_TX   = 0;      // op codes from addr bits 13..12
   localparam int UART_OP_POP  = 1;
   localparam int UART_OP_BAUD = 2;

   // uart constants
   localparam int BAUD_RESET      = 54;
   localparam int FIFO_DEPTH      = 16;
   localparam int FIFO_AW         = $clog2(FIFO_DEPTH);
   localparam int MAJ_TAPS        = 3;
   localparam int UART_FRAME_BITS = 10;  // start, 8 data, stop

endpackage

/* hdl/periph_slot_if.sv */
//********************
// decoded bus slot
// one host bus slot as seen by a peripheral
//********************

`timescale 1ns/1ps

interface periph_slot_if
   import periph_pkg::*;
   ();

   logic  sel;                           // slot addressed and en high
   logic  wr;                            // sel with any byte enable
   addr_t addr;
   data_t wrdata;
   data_t rdata;                         // combinational from peripheral

   modport host
   (
      output sel,
      output wr,
      output addr,
      output wrdata,
      input  rdata
   );

   modport periph
   (
      input  sel,
      input  wr,
      input  addr,
      input  wrdata,
      output rdata
   );

endinterface

/* hdl/periph_soc.sv */
//********************
// peripheral subsystem top
// slot decode, led and dip registers,
// uart slot and read data mux
//********************

`timescale 1ns/1ps

module periph_soc
   import periph_pkg::*;
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  logic        hid_en_i,
   input  be_t         hid_we_i,
   input  addr_t       hid_addr_i,
   input  data_t       hid_wrdata_i,
   output data_t       hid_rddata_o,
   input  logic [15:0] from_dip_i,
   output logic [7:0]  led_o,
   input  logic        uart_rx_i,
   output logic        uart_tx_o,
   output logic        uart_irq_o
);

   slot_t       slot;
   logic [4:0]  ofs;                     // control word offset
   logic        ctrl_wr;
   logic [15:0] dip_q;
   data_t       ctrl_rdata_q;

   periph_slot_if uart_bus ();

   assign slot    = hid_addr_i[17:15];
   assign ofs     = hid_addr_i[7:3];
   assign ctrl_wr = hid_en_i && (|hid_we_i) && (slot == slot_t'(SLOT_CTRL));

   assign uart_bus.sel    = hid_en_i && (slot == slot_t'(SLOT_UART));
   assign uart_bus.wr     = uart_bus.sel && (|hid_we_i);
   assign uart_bus.addr   = hid_addr_i;
   assign uart_bus.wrdata = hid_wrdata_i;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         led_o        <= '0;
         dip_q        <= '0;
         ctrl_rdata_q <= '0;
      end
      else
      begin
         dip_q <= from_dip_i;
         if (ctrl_wr && ofs == 5'(OFS_LED))
            led_o <= hid_wrdata_i[7:0];
         // registered read, one cycle behind the address
         ctrl_rdata_q <= (ofs == 5'(OFS_DIP)) ? data_t'(dip_q) : '0;
      end
   end

   uart_slot u_uart
   (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .bus        (uart_bus),
      .uart_rx_i  (uart_rx_i),
      .uart_tx_o  (uart_tx_o),
      .uart_irq_o (uart_irq_o)
   );

   // unused slots read zero
   always_comb
   begin
      hid_rddata_o = '0;
      if (slot == slot_t'(SLOT_CTRL))
         hid_rddata_o |= ctrl_rdata_q;
      if (slot == slot_t'(SLOT_UART))
         hid_rddata_o |= uart_bus.rdata;
   end

endmodule

/* hdl/sync_fifo.sv */
//********************
// single clock FIFO
// circular buffer with show-ahead output
// and free running push/pop counters
//********************

`timescale 1ns/1ps

module sync_fifo
   import periph_pkg::*;
#(
   parameter int WIDTH = 8
)
(
   input  logic             msoc_clk,
   input  logic             rstn,
   input  logic             push_i,
   input  logic             pop_i,
   input  logic [WIDTH-1:0] din_i,
   output logic [WIDTH-1:0] dout_o,
   output logic             full_o,
   output logic             empty_o,
   output fifo_cnt_t        wrcount_o,
   output fifo_cnt_t        rdcount_o
);

   logic [WIDTH-1:0] mem [FIFO_DEPTH];
   fifo_cnt_t        wr_cnt_q;
   fifo_cnt_t        rd_cnt_q;
   fifo_cnt_t        level;
   logic             push_ok;
   logic             pop_ok;

   // depth divides 4096, so the counters double as pointers
   assign level   = wr_cnt_q - rd_cnt_q;
   assign full_o  = (level == fifo_cnt_t'(FIFO_DEPTH));
   assign empty_o = (level == '0);
   assign push_ok = push_i && !full_o;   // drop when full
   assign pop_ok  = pop_i && !empty_o;

   assign dout_o    = mem[rd_cnt_q[FIFO_AW-1:0]];   // head, show-ahead
   assign wrcount_o = wr_cnt_q;
   assign rdcount_o = rd_cnt_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_cnt_q <= '0;
         rd_cnt_q <= '0;
      end
      else
      begin
         if (push_ok)
            wr_cnt_q <= wr_cnt_q + 1'b1;
         if (pop_ok)
            rd_cnt_q <= rd_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (push_ok)
         mem[wr_cnt_q[FIFO_AW-1:0]] <= din_i;
   end

endmodule

/* hdl/uart_rx.sv */
//********************
// uart receiver
// majority filtered line, start detect and
// mid-bit sampling into a byte with error flag
//********************

`timescale 1ns/1ps

module uart_rx
   import periph_pkg::*;
(
   input  logic      msoc_clk,
   input  logic      rstn,
   input  baud_t     baud_i,
   input  logic      rx_i,
   output logic      valid_o,
   output rx_entry_t entry_o
);

   typedef enum logic [1:0]
   {
      URX_IDLE,
      URX_START,
      URX_DATA,
      URX_STOP
   } urx_state_t;

   logic [MAJ_TAPS-1:0] samp_q;
   logic                line_q;          // filtered line
   logic                line_prev_q;
   urx_state_t          state_q;
   baud_t               cnt_q;
   logic [2:0]          bit_idx_q;
   uart_byte_t          data_q;
   logic                sample;

   function automatic logic vote(input logic [MAJ_TAPS-1:0] s);
      int ones;
      ones = 0;
      for (int i = 0; i < MAJ_TAPS; i++)
         ones += int'(s[i]);
      return ones > MAJ_TAPS / 2;
   endfunction

   assign sample = (cnt_q == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         samp_q      <= '1;
         line_q      <= 1'b1;
         line_prev_q <= 1'b1;
         state_q     <= URX_IDLE;
         cnt_q       <= '0;
         bit_idx_q   <= '0;
         valid_o     <= 1'b0;
      end
      else
      begin
         samp_q      <= {samp_q[MAJ_TAPS-2:0], rx_i};
         line_q      <= vote(samp_q);
         line_prev_q <= line_q;
         valid_o     <= 1'b0;
         if (state_q != URX_IDLE)
            cnt_q <= cnt_q - 16'd1;
         case (state_q)
            URX_IDLE:
               if (line_prev_q && !line_q)   // falling edge
               begin
                  state_q <= URX_START;
                  cnt_q   <= baud_i >> 1;    // to the middle of the start bit
               end
            URX_START:
               if (sample)
               begin
                  state_q   <= line_q ? URX_IDLE : URX_DATA;   // glitch goes back
                  cnt_q     <= baud_i - 16'd1;
                  bit_idx_q <= '0;
               end
            URX_DATA:
               if (sample)
               begin
                  cnt_q     <= baud_i - 16'd1;
                  bit_idx_q <= bit_idx_q + 3'd1;
                  if (bit_idx_q == 3'd7)
                     state_q <= URX_STOP;
               end
            default:
               if (sample)
               begin
                  valid_o <= 1'b1;
                  state_q <= URX_IDLE;
               end
         endcase
      end
   end

   // data shift and result capture
   always_ff @(posedge msoc_clk)
   begin
      if (state_q == URX_DATA && sample)
         data_q <= {line_q, data_q[7:1]};   // lsb arrives first
      if (state_q == URX_STOP && sample)
         entry_o <= {!line_q, data_q};      // low stop bit is a framing error
   end

endmodule

/* hdl/uart_slot.sv */
//********************
// uart register slot
// tx/rx FIFOs, baud register and the
// sequencer feeding the serializer
//********************

`timescale 1ns/1ps

module uart_slot
   import periph_pkg::*;
(
   input  logic               msoc_clk,
   input  logic               rstn,
   periph_slot_if.periph      bus,
   input  logic               uart_rx_i,
   output logic               uart_tx_o,
   output logic               uart_irq_o
);

   logic       uart_wr;
   logic [1:0] op;
   logic       tx_push_q;
   uart_byte_t tx_byte_q;
   uart_byte_t tx_head;
   uart_byte_t tx_hold_q;                // byte for the current frame
   logic       tx_full, tx_empty, tx_busy;
   fifo_cnt_t  tx_wrcount, tx_rdcount;
   logic       rx_pop, rx_valid;
   rx_entry_t  rx_entry, rx_head;
   logic       rx_full, rx_empty;
   fifo_cnt_t  rx_wrcount, rx_rdcount;
   baud_t      baud_q;
   utx_state_t state_q, state_d;

   assign uart_wr = bus.wr && bus.addr[UART_SEL_BIT];
   assign op      = bus.addr[13:12];
   assign rx_pop  = uart_wr && (op == 2'(UART_OP_POP));

   assign uart_irq_o = !rx_empty;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_push_q <= 1'b0;
         baud_q    <= baud_t'(BAUD_RESET);
         state_q   <= UTX_IDLE;
      end
      else
      begin
         tx_push_q <= uart_wr && (op == 2'(UART_OP_TX));   // push one cycle later
         if (uart_wr && op == 2'(UART_OP_BAUD))
            baud_q <= bus.wrdata[15:0];
         state_q <= state_d;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      tx_byte_q <= bus.wrdata[7:0];
      if (state_q == UTX_POP)
         tx_hold_q <= tx_head;           // head moves on after the pop
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         UTX_IDLE:  state_d = UTX_EMPTY;
         UTX_EMPTY: if (!tx_empty) state_d = UTX_POP;
         UTX_POP:   state_d = UTX_START;
         UTX_START: state_d = UTX_INUSE;
         UTX_INUSE: if (!tx_busy) state_d = UTX_IDLE;
         default:   state_d = UTX_IDLE;
      endcase
   end

   sync_fifo #(.WIDTH(8)) u_tx_fifo
   (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .push_i    (tx_push_q),
      .pop_i     (state_q == UTX_POP),
      .din_i     (tx_byte_q),
      .dout_o    (tx_head),
      .full_o    (tx_full),
      .empty_o   (tx_empty),
      .wrcount_o (tx_wrcount),
      .rdcount_o (tx_rdcount)
   );

   uart_tx u_tx
   (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .baud_i   (baud_q),
      .start_i  (state_q == UTX_START),
      .byte_i   (tx_hold_q),
      .busy_o   (tx_busy),
      .tx_o     (uart_tx_o)
   );

   uart_rx u_rx
   (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .baud_i   (baud_q),
      .rx_i     (uart_rx_i),
      .valid_o  (rx_valid),
      .entry_o  (rx_entry)
   );

   sync_fifo #(.WIDTH(9)) u_rx_fifo
   (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .push_i    (rx_valid),             // dropped when full
      .pop_i     (rx_pop),
      .din_i     (rx_entry),
      .dout_o    (rx_head),
      .full_o    (rx_full),
      .empty_o   (rx_empty),
      .wrcount_o (rx_wrcount),
      .rdcount_o (rx_rdcount)
   );

   // bit 13 picks counts over status, bit 14 low is the keyboard space
   always_comb
   begin
      bus.rdata = '0;
      if (bus.sel && bus.addr[UART_SEL_BIT])
      begin
         if (bus.addr[13])
            bus.rdata = {4'b0, tx_wrcount, 4'b0, tx_rdcount,
                         4'b0, rx_wrcount, 4'b0, rx_rdcount};
         else
            bus.rdata = data_t'({rx_full, tx_full, rx_empty, rx_head});
      end
   end

endmodule

/* hdl/uart_tx.sv */
//********************
// uart serializer
// sends one 8N1 frame per start pulse,
// each bit baud_i clocks long
//********************

`timescale 1ns/1ps

module uart_tx
   import periph_pkg::*;
(
   input  logic       msoc_clk,
   input  logic       rstn,
   input  baud_t      baud_i,
   input  logic       start_i,
   input  uart_byte_t byte_i,
   output logic       busy_o,
   output logic       tx_o
);

   logic [8:0] frame_q;                  // stop bit above data, lsb first
   logic [3:0] bit_cnt_q;
   baud_t      div_cnt_q;
   logic       bit_end;
   logic       launch;

   assign launch  = start_i && !busy_o;  // pulses during a frame are ignored
   assign bit_end = (div_cnt_q == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         busy_o    <= 1'b0;
         tx_o      <= 1'b1;              // line idles high
         bit_cnt_q <= '0;
         div_cnt_q <= '0;
      end
      else if (launch)
      begin
         busy_o    <= 1'b1;
         tx_o      <= 1'b0;              // start bit
         bit_cnt_q <= '0;
         div_cnt_q <= baud_i - 16'd1;
      end
      else if (busy_o)
      begin
         if (!bit_end)
            div_cnt_q <= div_cnt_q - 16'd1;
         else if (bit_cnt_q == 4'(UART_FRAME_BITS - 1))
         begin
            busy_o <= 1'b0;              // stop bit done
            tx_o   <= 1'b1;
         end
         else
         begin
            tx_o      <= frame_q[0];
            bit_cnt_q <= bit_cnt_q + 4'd1;
            div_cnt_q <= baud_i - 16'd1;
         end
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (launch)
         frame_q <= {1'b1, byte_i};
      else if (busy_o && bit_end)
         frame_q <= {1'b1, frame_q[8:1]};
   end

endmodule

/* tb/tb_periph_soc.sv */
//********************
// periph_soc testbench
// table driven loopback, framing error,
// baud change and counter checks
//********************

`timescale 1ns/1ps

module tb_periph_soc
   import periph_pkg::*;
   ();

   localparam int NTESTS   = 6;
   localparam int MAXBYTES = 4;
   localparam int OP_RESET = 0;
   localparam int OP_LOOP  = 1;
   localparam int OP_FRAME = 2;
   localparam int OP_BAUD  = 3;
   localparam int OP_COUNT = 4;

   logic        msoc_clk;
   logic        rstn;
   logic        hid_en;
   be_t         hid_we;
   addr_t       hid_addr;
   data_t       hid_wrdata;
   data_t       hid_rddata;
   logic [15:0] from_dip;
   logic [7:0]  led;
   logic        uart_rx;
   logic        uart_tx;
   logic        uart_irq;
   logic        inject_mode;             // line driven by the testbench
   logic        inject_line;

   // stimulus and expected values per test row
   int          test_op    [NTESTS];
   int          test_n     [NTESTS];
   int          test_div   [NTESTS];
   uart_byte_t  test_bytes [NTESTS][MAXBYTES];
   logic        test_err   [NTESTS];     // expected framing flag
   logic [15:0] test_dip   [NTESTS];

   int          seed;
   int          errors;
   int          checks;
   int          cycles;
   int          cycle_limit;
   logic        irq_seen;                // irq sampled with the last read
   fifo_cnt_t   tx_count;                // reference counts
   fifo_cnt_t   rx_push_count;
   fifo_cnt_t   rx_pop_count;

   assign uart_rx = inject_mode ? inject_line : uart_tx;   // serial loopback

   periph_soc dut
   (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en),
      .hid_we_i     (hid_we),
      .hid_addr_i   (hid_addr),
      .hid_wrdata_i (hid_wrdata),
      .hid_rddata_o (hid_rddata),
      .from_dip_i   (from_dip),
      .led_o        (led),
      .uart_rx_i    (uart_rx),
      .uart_tx_o    (uart_tx),
      .uart_irq_o   (uart_irq)
   );

   initial
   begin
      msoc_clk = 1'b0;
      forever
         #20 msoc_clk = ~msoc_clk;
   end

   initial
   begin
      cycles = 0;
      wait (cycle_limit > 0);
      while (cycles < cycle_limit)
      begin
         @(posedge msoc_clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the tests did not finish in time", cycles);
      $display("sim failed");
      $finish;
   end

   task automatic check_data(input string name, input data_t got, input data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_cnt(input string name, input fifo_cnt_t got, input fifo_cnt_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   function automatic addr_t uart_addr(input logic [1:0] op);
      return {slot_t'(SLOT_UART), 1'b1, op, 12'h000};
   endfunction

   function automatic addr_t ctrl_addr(input int ofs);
      return {slot_t'(SLOT_CTRL), 7'b0, 5'(ofs), 3'b000};
   endfunction

   // bus tasks start and end 1 ns after a rising edge
   task automatic write_word(input addr_t a, input data_t d);
      hid_en     = 1'b1;
      hid_we     = 8'hff;
      hid_addr   = a;
      hid_wrdata = d;
      @(posedge msoc_clk);
      #1;
      hid_en = 1'b0;
      hid_we = '0;
   endtask

   task automatic read_word(input addr_t a, output data_t d);
      hid_en   = 1'b1;
      hid_we   = '0;
      hid_addr = a;
      @(negedge msoc_clk);
      d        = hid_rddata;
      irq_seen = uart_irq;
      @(posedge msoc_clk);
      #1;
      hid_en = 1'b0;
   endtask

   task automatic pop_rx();
      write_word(uart_addr(2'(UART_OP_POP)), '0);
   endtask

   task automatic wait_rx(output data_t st);
      read_word(uart_addr(2'b00), st);
      while (st[9])                      // rx_empty
         read_word(uart_addr(2'b00), st);
   endtask

   task automatic send_bytes(input int r);
      for (int i = 0; i < test_n[r]; i++)
      begin
         write_word(uart_addr(2'(UART_OP_TX)), data_t'(test_bytes[r][i]));
         tx_count++;
         rx_push_count++;
      end
   endtask

   task automatic receive_bytes(input int r);
      data_t st;
      for (int i = 0; i < test_n[r]; i++)
      begin
         wait_rx(st);
         check_bit("uart_irq_o", irq_seen, 1'b1);
         check_bit("rx_err", st[8], test_err[r]);
         check_byte("rx_byte", st[7:0], test_bytes[r][i]);
         pop_rx();
         rx_pop_count++;
         read_word(uart_addr(2'b00), st);
         check_bit("rx_empty", st[9], 1'b1);   // next frame still on the line
         check_bit("uart_irq_o", irq_seen, 1'b0);
      end
   endtask

   // start bit, data lsb first, then the given stop bit
   task automatic inject_frame(input uart_byte_t b, input logic stop, input int div);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};
      for (int i = 0; i < UART_FRAME_BITS; i++)
      begin
         inject_line = bits[i];
         repeat (div) @(posedge msoc_clk);
         #1;
      end
      inject_line = 1'b1;
   endtask

   // needs a zero byte, so the line is low from start bit to bit 7
   task automatic measure_frame(input int div);
      int low;
      int high;
      low  = 0;
      high = 0;
      @(negedge msoc_clk);
      while (uart_tx !== 1'b0)
         @(negedge msoc_clk);
      while (uart_tx === 1'b0)
      begin
         low++;
         @(negedge msoc_clk);
      end
      while (uart_tx === 1'b1 && high < div)   // stop bit
      begin
         high++;
         @(negedge msoc_clk);
      end
      check_data("tx_low_run", data_t'(low), data_t'(9 * div));
      check_data("tx_frame_len", data_t'(low + high), data_t'(UART_FRAME_BITS * div));
      @(posedge msoc_clk);
      #1;
   endtask

   task automatic reset_state_test(input int r);
      data_t rd;
      read_word(uart_addr(2'b00), rd);
      check_bit("rx_full", rd[11], 1'b0);
      check_bit("tx_full", rd[10], 1'b0);
      check_bit("rx_empty", rd[9], 1'b1);
      check_bit("uart_irq_o", irq_seen, 1'b0);
      write_word(ctrl_addr(OFS_LED), data_t'(test_bytes[r][0]));
      check_byte("led_o", led, test_bytes[r][0]);
      from_dip = test_dip[r];
      hid_en   = 1'b1;
      hid_addr = ctrl_addr(OFS_DIP);
      repeat (2) @(posedge msoc_clk);    // dip register then read register
      @(negedge msoc_clk);
      rd = hid_rddata;
      @(posedge msoc_clk);
      #1;
      hid_en = 1'b0;
      check_data("hid_rddata_o", rd, data_t'(test_dip[r]));
   endtask

   task automatic counter_test();
      data_t rd;
      read_word(uart_addr(2'b10), rd);
      check_cnt("tx_wrcount", rd[59:48], tx_count);
      check_cnt("tx_rdcount", rd[43:32], tx_count);
      check_cnt("rx_wrcount", rd[27:16], rx_push_count);
      check_cnt("rx_rdcount", rd[11:0], rx_pop_count);
      pop_rx();                          // receive FIFO is empty here
      read_word(uart_addr(2'b10), rd);
      check_cnt("rx_rdcount", rd[11:0], rx_pop_count);
      read_word(uart_addr(2'b00), rd);
      check_bit("rx_empty", rd[9], 1'b1);
   endtask

   task automatic set_row(input int r, input int op, input int n, input int div,
                          input logic err, input logic [31:0] bytes, input logic [15:0] dip);
      test_op[r]  = op;
      test_n[r]   = n;
      test_div[r] = div;
      test_err[r] = err;
      test_dip[r] = dip;
      for (int i = 0; i < MAXBYTES; i++)
         test_bytes[r][i] = bytes[8*i +: 8];
   endtask

   task automatic fill_table();
      logic [31:0] rnd;
      rnd = $random(seed);
      set_row(0, OP_RESET, 0, BAUD_RESET, 1'b0, 32'h0000_005a, 16'hc3a5);
      set_row(1, OP_LOOP, 4, BAUD_RESET, 1'b0, 32'hff00_a355, 16'h0);
      set_row(2, OP_LOOP, 4, BAUD_RESET, 1'b0, rnd, 16'h0);
      set_row(3, OP_FRAME, 1, BAUD_RESET, 1'b1, 32'h0000_00c6, 16'h0);
      rnd = $random(seed);
      set_row(4, OP_BAUD, 3, 20, 1'b0, {8'h00, 8'h3c, rnd[7:0], 8'h00}, 16'h0);
      set_row(5, OP_COUNT, 0, 20, 1'b0, 32'h0, 16'h0);
   endtask

   function automatic int limit_from_table();
      int sum;
      sum = 200;                         // margin
      for (int r = 0; r < NTESTS; r++)
         sum += test_n[r] * UART_FRAME_BITS * test_div[r];
      return sum;
   endfunction

   function automatic string op_name(input int op);
      case (op)
         OP_RESET: return "reset state";
         OP_LOOP:  return "loopback";
         OP_FRAME: return "framing error";
         OP_BAUD:  return "baud change";
         default:  return "counters";
      endcase
   endfunction

   initial
   begin
      int err_start;
      seed          = 92;
      errors        = 0;
      checks        = 0;
      tx_count      = '0;
      rx_push_count = '0;
      rx_pop_count  = '0;
      rstn          = 1'b0;
      hid_en        = 1'b0;
      hid_we        = '0;
      hid_addr      = '0;
      hid_wrdata    = '0;
      from_dip      = '0;
      inject_mode   = 1'b0;
      inject_line   = 1'b1;              // idle high
      fill_table();
      cycle_limit = limit_from_table();
      repeat (8) @(posedge msoc_clk);
      #1;
      rstn = 1'b1;
      for (int r = 0; r < NTESTS; r++)
      begin
         err_start = errors;
         case (test_op[r])
            OP_RESET:
               reset_state_test(r);
            OP_LOOP:
            begin
               send_bytes(r);
               receive_bytes(r);
            end
            OP_FRAME:
            begin
               inject_mode = 1'b1;
               inject_frame(test_bytes[r][0], 1'b0, test_div[r]);
               inject_mode = 1'b0;
               rx_push_count++;
               receive_bytes(r);
            end
            OP_BAUD:
            begin
               write_word(uart_addr(2'(UART_OP_BAUD)), data_t'(test_div[r]));
               send_bytes(r);
               measure_frame(test_div[r]);
               receive_bytes(r);
            end
            default:
               counter_test();
         endcase
         $display("test %0d %s finished, %0d errors", r, op_name(test_op[r]),
                  errors - err_start);
      end
      $display("%0d tests, %0d checks, %0d errors", NTESTS, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule
